//--- dv/obj_subsys_tb.sv
// testbench for the object subsystem, drives cpu and config writes and checks banked scans
`timescale 1ns/1ps
`include "objram_macros.svh"

module obj_subsys_tb;

    logic                   rst;
    logic                   clk_cpu;
    logic                   obank;
    logic                   cfg_cs;
    objram_pkg::cfg_wr_t    cfg;
    logic                   cs;
    objram_pkg::cpu_wr_t    wr;
    logic                   ok;
    logic                   frame_start;
    logic                   obj_valid;
    objram_pkg::obj_entry_t obj;
    logic                   obj_ready;
    logic                   scan_done;

    // expected records, key is bank * 1024 + entry
    objram_pkg::obj_entry_t ref_tab [int];
    // model copies of the offset registers
    logic [9:0]             m_offx;
    logic [8:0]             m_offy;
    // records taken by the consumer during one scan
    objram_pkg::obj_entry_t got [$];
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;
    int cs_seen = 0;
    int ok_seen = 0;
    int mark;

    obj_subsys_top dut (.*);

    initial begin
        clk_cpu = 1'b0;
        forever #10 clk_cpu = ~clk_cpu;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // cycle limit, plus access and ack counts
    always @(posedge clk_cpu) begin
        cycles++;
        if (!rst && cs) cs_seen++;
        if (!rst && ok) ok_seen++;
        if (cycles == 4000) begin
            $display("run stopped: cycle limit reached before all tests finished");
            $display("Verification failed");
            $finish;
        end
    end

    // ack exactly one cycle after each access
    a_cs_then_ok: assert property (@(posedge clk_cpu) disable iff (rst) cs |=> ok)
        else report_error("ok missing one cycle after cs");
    a_ok_needs_cs: assert property (@(posedge clk_cpu) disable iff (rst) ok |-> $past(cs))
        else report_error("ok without cs the cycle before");
    // done is a single pulse
    a_done_pulse: assert property (@(posedge clk_cpu) disable iff (rst) scan_done |=> !scan_done)
        else report_error("scan_done longer than one cycle");
    // stalled offer holds
    a_stall_hold: assert property (@(posedge clk_cpu) disable iff (rst)
        obj_valid && !obj_ready |=> obj_valid && $stable(obj))
        else report_error("offer dropped or changed while stalled");
    // end marker is never handed out
    a_no_end_offer: assert property (@(posedge clk_cpu) disable iff (rst)
        obj_valid |-> obj.attr != `OBJ_END_ATTR)
        else report_error("end marker offered to the consumer");

    task automatic cfg_write(input logic [2:0] reg_no, input logic [1:0] dsn,
                             input logic [15:0] d);
        @(negedge clk_cpu);
        cfg_cs   = 1'b1;
        cfg.dsn  = dsn;
        cfg.addr = reg_no;
        cfg.data = d;
        // unstrobed lanes keep the old offset bits, then the bias comes off
        if (dsn != 2'b11 && reg_no == `OBJ_XOFF_REG) begin
            m_offx = {dsn[1] ? m_offx[9:8] : d[9:8], dsn[0] ? m_offx[7:0] : d[7:0]} - `OBJ_XBIAS;
        end
        if (dsn != 2'b11 && reg_no == `OBJ_YOFF_REG) begin
            m_offy = {dsn[1] ? m_offy[8] : d[8], dsn[0] ? m_offy[7:0] : d[7:0]} - `OBJ_YBIAS;
        end
        @(negedge clk_cpu);
        cfg_cs = 1'b0;
    endtask

    task automatic cpu_write(input logic top, input int ent, input int word,
                             input logic [1:0] dsn, input logic [15:0] d);
        int          key;
        logic [15:0] val;
        logic [15:0] cur;
        @(negedge clk_cpu);
        cs      = 1'b1;
        wr.dsn  = dsn;
        wr.data = d;
        wr.addr = {top, 9'(ent), 2'(word), 1'b0};
        key = ((obank ^ top) ? 1024 : 0) + ent;
        // positions lose the offset in the low 10 bits only
        case (word)
            0: val = {d[15:10], d[9:0] - m_offx};
            1: val = {d[15:10], d[9:0] - {m_offy[8], m_offy}};
            default: val = d;
        endcase
        if (!ref_tab.exists(key)) ref_tab[key] = '0;
        cur = ref_tab[key][63 - 16 * word -: 16];
        if (!dsn[0]) cur[7:0] = val[7:0];
        if (!dsn[1]) cur[15:8] = val[15:8];
        ref_tab[key][63 - 16 * word -: 16] = cur;
        @(negedge clk_cpu);
        cs = 1'b0;
    endtask

    // full record, attr kept clear of the end marker
    task automatic write_random(input int bank, input int ent);
        logic top;
        top = bank[0] ^ obank;
        cpu_write(top, ent, 0, 2'b00, 16'($urandom));
        cpu_write(top, ent, 1, 2'b00, 16'($urandom));
        cpu_write(top, ent, 2, 2'b00, 16'($urandom));
        cpu_write(top, ent, 3, 2'b00, 16'($urandom) & 16'h7fff);
    endtask

    task automatic write_end(input int bank, input int ent);
        cpu_write(bank[0] ^ obank, ent, 3, 2'b00, `OBJ_END_ATTR);
    endtask

    task automatic run_scan(input int ready_pct);
        got.delete();
        @(negedge clk_cpu);
        frame_start = 1'b1;
        do begin
            @(negedge clk_cpu);
            frame_start = 1'b0;
            obj_ready = ($urandom_range(99) < ready_pct);
            // valid and ready as seen by the coming edge
            if (obj_valid && obj_ready) got.push_back(obj);
        end while (!scan_done);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("test %s: PASS", name);
        end else begin
            failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    // records in index order, exactly n of them
    task automatic check_scan(input string name, input int bank, input int n);
        assert (got.size() == n)
            else report_error($sformatf("%s: %0d records, expected %0d", name, got.size(), n));
        foreach (got[i]) begin
            if (i < n) begin
                assert (got[i] == ref_tab[bank * 1024 + i])
                    else report_error($sformatf("%s: entry %0d is %h, expected %h",
                                                name, i, got[i], ref_tab[bank * 1024 + i]));
            end
        end
        finish_test(name, mark);
    endtask

    initial begin
        void'($urandom(32'hcc72_55bb));
        rst         = 1'b1;
        obank       = 1'b0;
        cfg_cs      = 1'b0;
        cfg         = '0;
        cs          = 1'b0;
        wr          = '0;
        frame_start = 1'b0;
        obj_ready   = 1'b0;
        m_offx      = '0;
        m_offy      = '0;
        repeat (5) @(negedge clk_cpu);
        rst = 1'b0;

        // quiet outputs after reset, then a scan of an empty table
        mark = errors;
        assert (!ok && !obj_valid && !scan_done)
            else report_error("outputs not low after reset");
        write_end(1, 0);
        run_scan(100);
        check_scan("reset_and_empty_scan", 1, 0);

        // back-to-back accesses with no lane strobed
        mark = errors;
        @(negedge clk_cpu);
        cs     = 1'b1;
        wr.dsn = 2'b11;
        repeat (3) @(negedge clk_cpu);
        cs = 1'b0;
        repeat (2) @(negedge clk_cpu);
        assert (cs_seen == ok_seen)
            else report_error($sformatf("%0d accesses but %0d acks", cs_seen, ok_seen));
        finish_test("ok_per_access", mark);

        // offsets, one with a negative y, then single lane updates
        mark = errors;
        cfg_write(`OBJ_XOFF_REG, 2'b00, 16'h0123);
        cfg_write(`OBJ_YOFF_REG, 2'b00, 16'h0008);
        cfg_write(`OBJ_YOFF_REG, 2'b10, 16'($urandom));
        cfg_write(`OBJ_XOFF_REG, 2'b01, 16'($urandom));
        for (int e = 0; e < 4; e++) write_random(1, e);
        write_end(1, 4);
        run_scan(75);
        check_scan("offset_correction", 1, 4);

        // one lane of a stored word
        mark = errors;
        cpu_write(~obank, 1, 2, 2'b10, 16'($urandom));
        cpu_write(~obank, 2, 0, 2'b01, 16'($urandom));
        cpu_write(~obank, 3, 1, 2'b10, 16'($urandom));
        run_scan(75);
        check_scan("partial_writes", 1, 4);

        // top bit clear with obank 1 lands in bank 1
        mark = errors;
        @(negedge clk_cpu);
        obank = 1'b1;
        for (int e = 0; e < 3; e++) write_random(1, e);
        write_end(1, 3);
        for (int e = 0; e < 5; e++) write_random(0, e);
        write_end(0, 5);
        @(negedge clk_cpu);
        obank = 1'b0;
        run_scan(75);
        check_scan("bank_select_0", 1, 3);
        mark = errors;
        @(negedge clk_cpu);
        obank = 1'b1;
        run_scan(75);
        check_scan("bank_select_1", 0, 5);

        // heavy back-pressure over a longer table
        mark = errors;
        for (int e = 0; e < 12; e++) write_random(0, e);
        write_end(0, 12);
        run_scan(50);
        check_scan("random_ready", 0, 12);

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hdl/obj_dual_ram.sv
// 16-bit word memory with one byte-enabled write port and one registered read port
`timescale 1ns/1ps

module obj_dual_ram #(
    parameter AW = 11
) (
    input  logic          clk_cpu,
    input  logic [AW-1:0] wr_addr,
    input  logic [1:0]    wr_en,
    input  logic [15:0]   wr_data,
    input  logic [AW-1:0] rd_addr,
    output logic [15:0]   rd_data
);

    // storage, no reset
    logic [15:0] mem [2**AW];

    // byte lanes written independently
    always_ff @(posedge clk_cpu) begin
        if (wr_en[0]) begin
            mem[wr_addr][7:0] <= wr_data[7:0];
        end
        if (wr_en[1]) begin
            mem[wr_addr][15:8] <= wr_data[15:8];
        end
    end

    // read before write on an address collision
    always_ff @(posedge clk_cpu) begin
        rd_data <= mem[rd_addr];
    end

    // a lane write must always target a known word
    a_wr_addr_known: assert property (
        @(posedge clk_cpu) (|wr_en) |-> !$isunknown(wr_addr)
    ) else $error("write with unknown address");

endmodule

//--- hdl/obj_scan_counter.sv
// entry index counter for the table scan, with clear, step and end-of-table flag
`timescale 1ns/1ps

module obj_scan_counter #(
    parameter LIMIT = 1024
) (
    input  logic       rst,
    input  logic       clk_cpu,
    input  logic       clear,
    input  logic       step,
    output logic [9:0] index,
    output logic       last
);

    // index of the final entry of a bank
    localparam logic [9:0] LAST_IDX = 10'(LIMIT - 1);

    // clear wins over step
    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (step) begin
            index <= index + 10'd1;
        end
    end

    assign last = (index == LAST_IDX);

    // the controller must stop at the limit, never wrap
    a_no_step_past_last: assert property (
        @(posedge clk_cpu) disable iff (rst) !(step && last)
    ) else $error("scan stepped past the last entry");

endmodule

//--- hdl/obj_scan_ctrl.sv
// scan FSM that walks the visible bank and offers each record under valid/ready
`timescale 1ns/1ps
`include "objram_macros.svh"

module obj_scan_ctrl (
    input  logic                   rst,
    input  logic                   clk_cpu,
    input  logic                   frame_start,
    input  objram_pkg::obj_entry_t entry,
    output logic                   cnt_clear,
    output logic                   cnt_step,
    input  logic                   cnt_last,
    output logic                   obj_valid,
    output objram_pkg::obj_entry_t obj,
    input  logic                   obj_ready,
    output logic                   scan_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_WAIT,
        S_OFFER,
        S_FINISH
    } state_t;

    state_t state;
    state_t state_nxt;
    // end marker seen on the returned record
    logic   is_end;

    assign is_end = (entry.attr == `OBJ_END_ATTR);

    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        cnt_clear = 1'b0;
        cnt_step  = 1'b0;
        case (state)
            // frame_start only counts here
            S_IDLE: begin
                if (frame_start) begin
                    cnt_clear = 1'b1;
                    state_nxt = S_READ;
                end
            end
            // index on the ram address this cycle
            S_READ: state_nxt = S_WAIT;
            // record on the ram output, captured below
            S_WAIT: state_nxt = is_end ? S_FINISH : S_OFFER;
            // hold until the consumer takes it, no new read meanwhile
            S_OFFER: begin
                if (obj_ready) begin
                    if (cnt_last) begin
                        state_nxt = S_FINISH;
                    end else begin
                        cnt_step  = 1'b1;
                        state_nxt = S_READ;
                    end
                end
            end
            S_FINISH: state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    // payload register, loaded once per entry
    always_ff @(posedge clk_cpu) begin
        if (state == S_WAIT) begin
            obj <= entry;
        end
    end

    assign obj_valid = (state == S_OFFER);
    // single cycle, the FSM leaves S_FINISH at once
    assign scan_done = (state == S_FINISH);

    // a stalled offer keeps valid up and the payload frozen
    a_hold_on_stall: assert property (
        @(posedge clk_cpu) disable iff (rst)
        obj_valid && !obj_ready |=> obj_valid && $stable(obj)
    ) else $error("payload changed under back-pressure");

endmodule

//--- hdl/obj_subsys_top.sv
// object subsystem top: table ram, scan counter and scan FSM wired together
`timescale 1ns/1ps
`include "objram_macros.svh"

module obj_subsys_top (
    input  logic                   rst,
    input  logic                   clk_cpu,
    input  logic                   obank,
    input  logic                   cfg_cs,
    input  objram_pkg::cfg_wr_t    cfg,
    input  logic                   cs,
    input  objram_pkg::cpu_wr_t    wr,
    output logic                   ok,
    input  logic                   frame_start,
    output logic                   obj_valid,
    output objram_pkg::obj_entry_t obj,
    input  logic                   obj_ready,
    output logic                   scan_done
);

    // record read back from the visible bank
    objram_pkg::obj_entry_t entry;
    logic [9:0]             index;
    logic                   cnt_clear;
    logic                   cnt_step;
    logic                   cnt_last;

    obj_table_ram #(.AW(`OBJ_AW)) u_table (
        .rst      (rst),
        .clk_cpu  (clk_cpu),
        .obank    (obank),
        .cfg_cs   (cfg_cs),
        .cfg      (cfg),
        .cs       (cs),
        .wr       (wr),
        .ok       (ok),
        .rd_index (index),
        .entry    (entry)
    );

    obj_scan_counter #(.LIMIT(`OBJ_SCAN_LIMIT)) u_cnt (
        .rst     (rst),
        .clk_cpu (clk_cpu),
        .clear   (cnt_clear),
        .step    (cnt_step),
        .index   (index),
        .last    (cnt_last)
    );

    obj_scan_ctrl u_ctrl (
        .rst         (rst),
        .clk_cpu     (clk_cpu),
        .frame_start (frame_start),
        .entry       (entry),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .cnt_last    (cnt_last),
        .obj_valid   (obj_valid),
        .obj         (obj),
        .obj_ready   (obj_ready),
        .scan_done   (scan_done)
    );

endmodule

//--- hdl/obj_table_ram.sv
// double-banked object table with offset registers and position correction on the cpu side
`timescale 1ns/1ps
`include "objram_macros.svh"

module obj_table_ram #(
    parameter AW = `OBJ_AW
) (
    input  logic                   rst,
    input  logic                   clk_cpu,
    input  logic                   obank,
    input  logic                   cfg_cs,
    input  objram_pkg::cfg_wr_t    cfg,
    input  logic                   cs,
    input  objram_pkg::cpu_wr_t    wr,
    output logic                   ok,
    input  logic [AW-4:0]          rd_index,
    output objram_pkg::obj_entry_t entry
);

    // global position offsets
    logic [9:0]    off_x;
    logic [8:0]    off_y;
    // written value with old bits in unstrobed lanes, bias removed
    logic [9:0]    next_offx;
    logic [8:0]    next_offy;
    // one-hot word select and byte lanes of this cycle
    logic [3:0]    word_sel;
    logic [1:0]    lane_en;
    logic          wr_bank;
    // write stage feeding the rams
    logic [15:0]   din_x;
    logic [15:0]   din_y;
    logic [15:0]   din_raw;
    logic [1:0]    we_x;
    logic [1:0]    we_y;
    logic [1:0]    we_code;
    logic [1:0]    we_attr;
    logic [AW-3:0] wr_addr_q;
    // graphics side always on the other bank
    logic [AW-3:0] rd_addr;

    assign next_offx = {cfg.dsn[1] ? off_x[9:8] : cfg.data[9:8],
                        cfg.dsn[0] ? off_x[7:0] : cfg.data[7:0]} - `OBJ_XBIAS;
    assign next_offy = {cfg.dsn[1] ? off_y[8]   : cfg.data[8],
                        cfg.dsn[0] ? off_y[7:0] : cfg.data[7:0]} - `OBJ_YBIAS;

    // a config write with no strobe low leaves the offset alone
    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            off_x <= '0;
            off_y <= '0;
        end else if (cfg_cs && cfg.dsn != 2'b11) begin
            if (cfg.addr == `OBJ_XOFF_REG) begin
                off_x <= next_offx;
            end
            if (cfg.addr == `OBJ_YOFF_REG) begin
                off_y <= next_offy;
            end
        end
    end

    // word lane from address bits 2:1
    assign word_sel = 4'b0001 << wr.addr[2:1];
    assign lane_en  = ~wr.dsn & {2{cs}};
    assign wr_bank  = obank ^ wr.addr[AW-1];

    // strobes and ack, one cycle behind cs
    always_ff @(posedge clk_cpu or posedge rst) begin
        if (rst) begin
            ok      <= 1'b0;
            we_x    <= '0;
            we_y    <= '0;
            we_code <= '0;
            we_attr <= '0;
        end else begin
            ok      <= cs;
            we_x    <= lane_en & {2{word_sel[0]}};
            we_y    <= lane_en & {2{word_sel[1]}};
            we_code <= lane_en & {2{word_sel[2]}};
            we_attr <= lane_en & {2{word_sel[3]}};
        end
    end

    // corrected positions, only the low 10 bits move
    // y offset is sign extended to 10 bits
    always_ff @(posedge clk_cpu) begin
        din_x     <= {wr.data[15:10], wr.data[9:0] - off_x};
        din_y     <= {wr.data[15:10], wr.data[9:0] - {off_y[8], off_y}};
        din_raw   <= wr.data;
        wr_addr_q <= {wr_bank, 1'b0, wr.addr[AW-2:3]};
    end

    assign rd_addr = {~obank, rd_index};

    obj_dual_ram #(.AW(AW-2)) u_x (
        .clk_cpu (clk_cpu),
        .wr_addr (wr_addr_q),
        .wr_en   (we_x),
        .wr_data (din_x),
        .rd_addr (rd_addr),
        .rd_data (entry.x)
    );

    obj_dual_ram #(.AW(AW-2)) u_y (
        .clk_cpu (clk_cpu),
        .wr_addr (wr_addr_q),
        .wr_en   (we_y),
        .wr_data (din_y),
        .rd_addr (rd_addr),
        .rd_data (entry.y)
    );

    obj_dual_ram #(.AW(AW-2)) u_code (
        .clk_cpu (clk_cpu),
        .wr_addr (wr_addr_q),
        .wr_en   (we_code),
        .wr_data (din_raw),
        .rd_addr (rd_addr),
        .rd_data (entry.code)
    );

    obj_dual_ram #(.AW(AW-2)) u_attr (
        .clk_cpu (clk_cpu),
        .wr_addr (wr_addr_q),
        .wr_en   (we_attr),
        .wr_data (din_raw),
        .rd_addr (rd_addr),
        .rd_data (entry.attr)
    );

    // every ack answers a cpu access of the cycle before
    a_ok_follows_cs: assert property (
        @(posedge clk_cpu) disable iff (rst) ok |-> $past(cs)
    ) else $error("ok without cs");

endmodule

//--- hdl/objram_macros.svh
// object table sizing and register constants, included by the package and the rtl that needs them
`ifndef OBJRAM_MACROS_SVH
`define OBJRAM_MACROS_SVH

// cpu word address width, two banks of 4 KWords
`define OBJ_AW 13

// entries walked per frame, one full bank
`define OBJ_SCAN_LIMIT 1024

// bias removed from the value written to each offset register
`define OBJ_XBIAS 10'h040
`define OBJ_YBIAS 9'h010

// attribute word that terminates the table
`define OBJ_END_ATTR 16'hff00

// config register numbers of the position offsets
`define OBJ_XOFF_REG 3'd4
`define OBJ_YOFF_REG 3'd5

`endif

//--- hdl/objram_pkg.sv
// record and bus structs of the object table, referenced by scoped name from the rtl
`include "objram_macros.svh"

package objram_pkg;

    // one object record as handed to the consumer
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
    } obj_entry_t;

    // cpu write into the table
    typedef struct packed {
        // active low byte strobes, bit 1 is the upper byte
        logic [1:0]          dsn;
        logic [15:0]         data;
        // bits 2:1 word, top bit flips the bank
        logic [`OBJ_AW-1:0] addr;
    } cpu_wr_t;

    // write to the config register file
    typedef struct packed {
        // active low byte strobes
        logic [1:0]  dsn;
        // register number
        logic [2:0]  addr;
        logic [15:0] data;
    } cfg_wr_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the object subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module obj_subsys_tb -Mdir obj_dir -o obj_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/obj_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

//--- src.f
+incdir+hdl
hdl/objram_pkg.sv
hdl/obj_dual_ram.sv
hdl/obj_table_ram.sv
hdl/obj_scan_counter.sv
hdl/obj_scan_ctrl.sv
hdl/obj_subsys_top.sv
dv/obj_subsys_tb.sv
